// ==== logic/sys_core_macros.svh ====
// Widths and codes fixed for a 16-bit host word and 16-bit audio, change with care
`default_nettype none

`ifndef SYS_CORE_MACROS_SVH
`define SYS_CORE_MACROS_SVH

// Data widths
`define SYS_IO_WIDTH    16
`define SYS_AUDIO_WIDTH 16
`define SYS_LED_COUNT   8
`define SYS_VOL_BITS    5

// Button debounce
`define SYS_DEB_DEPTH   8
`define SYS_DEB_DIV     100000

// Host command codes
`define SYS_CMD_CFG     8'h01
`define SYS_CMD_LED     8'h25
`define SYS_CMD_VOL     8'h26

`endif

`default_nettype wire

// ==== logic/sys_core_pkg.sv ====
// Shared types, field positions of video_cfg_t follow the host cfg word bit for bit
`include "sys_core_macros.svh"
`default_nettype none

package sys_core_pkg;

	// Host command opcodes
	typedef enum logic [7:0] {
		cmd_cfg = `SYS_CMD_CFG,
		cmd_led = `SYS_CMD_LED,
		cmd_vol = `SYS_CMD_VOL
	} host_cmd_e;

	typedef enum logic {
		link_idle     = 1'b0,
		link_have_cmd = 1'b1
	} link_state_e;

	// Share of the opposite channel mixed in
	typedef enum logic [1:0] {
		mix_none    = 2'd0,
		mix_eighth  = 2'd1,
		mix_quarter = 2'd2,
		mix_half    = 2'd3
	} mix_mode_e;

	typedef struct packed {
		logic [7:0] rsvd_hi;
		logic       dvi_mode;
		logic       audio_96k;
		logic       ypbpr_en;
		logic       rsvd_4;
		logic       csync;
		logic       vga_scaler;
		logic [1:0] rsvd_lo;
	} video_cfg_t;

	typedef struct packed {
		video_cfg_t                cfg;
		logic [`SYS_LED_COUNT-1:0] led_overtake;
		logic [`SYS_LED_COUNT-1:0] led_state;
		logic [`SYS_VOL_BITS-1:0]  vol_att;
	} host_settings_t;

	// Lamp requests from the core
	typedef struct packed {
		logic       user;
		logic [1:0] power;
		logic [1:0] disk;
	} led_req_t;

	typedef struct packed {
		logic [`SYS_AUDIO_WIDTH-1:0] left;
		logic [`SYS_AUDIO_WIDTH-1:0] right;
	} audio_pair_t;

endpackage

`default_nettype wire

// ==== logic/host_link.sv ====
// Host must hold io_din and io_clk high until io_ack rises, and wait for io_ack low after
`timescale 1ns/1ps
`include "sys_core_macros.svh"
`default_nettype none

module host_link (
	input  logic                       clk_sys,
	input  logic                       resetd,
	input  logic                       io_uio,
	input  logic                       io_clk,
	input  logic [`SYS_IO_WIDTH-1:0]   io_din,
	output logic                       io_ack,
	output sys_core_pkg::host_settings_t settings
);

	import sys_core_pkg::*;

	// ============================================================
	// Strobe detection and acknowledge
	// ============================================================

	logic clk_q;
	logic strobe;

	// One-cycle pulse on the first clk_sys sample of io_clk high
	assign strobe = io_clk & ~clk_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_q  <= 1'b0;
			io_ack <= 1'b0;
		end else begin
			clk_q  <= io_clk;
			io_ack <= clk_q;
		end
	end

	// ============================================================
	// Command FSM and settings registers
	// ============================================================

	link_state_e state;
	host_cmd_e   cmd_q;

	// Command byte is only meaningful in link_have_cmd
	always_ff @(posedge clk_sys) begin
		if (state == link_idle && io_uio && strobe) begin
			cmd_q <= host_cmd_e'(io_din[7:0]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state <= link_idle;
		end else if (!io_uio) begin
			state <= link_idle;
		end else if (strobe) begin
			state <= link_have_cmd;
		end
	end

	// Data words land the cycle after the strobe, one before io_ack
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			settings <= '0;
		end else if (io_uio && strobe && state == link_have_cmd) begin
			case (cmd_q)
				cmd_cfg: begin
					settings.cfg <= video_cfg_t'(io_din);
				end
				cmd_led: begin
					{settings.led_overtake, settings.led_state} <= io_din;
				end
				cmd_vol: begin
					settings.vol_att <= io_din[`SYS_VOL_BITS-1:0];
				end
				default: begin
					// Unknown command, data dropped
				end
			endcase
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	a_ack_after_clk: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$rose(io_ack) |-> $past(io_clk, 2)
	) else $error("io_ack rose without io_clk high two cycles before");

endmodule

`default_nettype wire

// ==== logic/panel_io.sv ====
// Buttons and keys are active low, tick_div sets debounce rate and must be at least 2
`timescale 1ns/1ps
`include "sys_core_macros.svh"
`default_nettype none

module panel_io #(
	parameter int tick_div = `SYS_DEB_DIV
) (
	input  logic                         clk_sys,
	input  logic                         resetd,
	input  logic                         btn_user_n,
	input  logic                         btn_osd_n,
	input  logic [1:0]                   key_n,
	input  sys_core_pkg::led_req_t       led_req,
	input  sys_core_pkg::host_settings_t settings,
	output logic                         btn_user,
	output logic                         btn_osd,
	output logic                         lamp_power,
	output logic                         lamp_disk,
	output logic                         lamp_user,
	output logic [`SYS_LED_COUNT-1:0]    board_led
);

	localparam int DIV_W = (tick_div > 1) ? $clog2(tick_div) : 1;

	// ============================================================
	// Debounce
	// ============================================================

	logic [DIV_W-1:0]          div_cnt;
	logic                      tick;
	logic [1:0]                pressed;
	logic [1:0]                btn_q;
	logic [`SYS_DEB_DEPTH-1:0] hist      [2];
	logic [`SYS_DEB_DEPTH-1:0] hist_next [2];

	assign tick = (div_cnt == '0);

	// Index 1 is user with key 1, index 0 is OSD with key 0
	assign pressed[1] = ~(btn_user_n & key_n[1]);
	assign pressed[0] = ~(btn_osd_n & key_n[0]);

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			hist_next[i] = {hist[i][`SYS_DEB_DEPTH-2:0], pressed[i]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div_cnt <= '0;
		end else if (div_cnt == DIV_W'(tick_div - 1)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// State flips on the tick whose sample completes the run
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			btn_q <= '0;
			for (int i = 0; i < 2; i++) begin
				hist[i] <= '0;
			end
		end else if (tick) begin
			for (int i = 0; i < 2; i++) begin
				hist[i] <= hist_next[i];
				if (&hist_next[i]) begin
					btn_q[i] <= 1'b1;
				end
				if (~|hist_next[i]) begin
					btn_q[i] <= 1'b0;
				end
			end
		end
	end

	assign btn_user = btn_q[1];
	assign btn_osd  = btn_q[0];

	// ============================================================
	// Lamps and board LEDs
	// ============================================================

	logic                      power_d;
	logic                      disk_d;
	logic                      user_d;
	logic [`SYS_LED_COUNT-1:0] lamp_vec;

	assign power_d = led_req.power[1] & led_req.power[0];
	assign disk_d  = led_req.disk[0];
	assign user_d  = led_req.user;

	always_comb begin
		lamp_vec    = '0;
		lamp_vec[0] = user_d;
		lamp_vec[2] = disk_d;
		lamp_vec[4] = power_d;
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			lamp_power <= 1'b0;
			lamp_disk  <= 1'b0;
			lamp_user  <= 1'b0;
			board_led  <= '0;
		end else begin
			lamp_power <= power_d;
			lamp_disk  <= disk_d;
			lamp_user  <= user_d;
			// Host override wins bit by bit
			board_led  <= (settings.led_overtake & settings.led_state) |
			              (~settings.led_overtake & lamp_vec);
		end
	end

endmodule

`default_nettype wire

// ==== logic/audio_channel.sv ====
// Two-cycle pipeline where vol_att is taken live at the second stage and sums wrap to 16 bits
`timescale 1ns/1ps
`include "sys_core_macros.svh"
`default_nettype none

module audio_channel (
	input  logic                          clk_sys,
	input  logic                          resetd,
	input  logic [`SYS_AUDIO_WIDTH-1:0]   own,
	input  logic [`SYS_AUDIO_WIDTH-1:0]   opposite,
	input  logic                          audio_signed,
	input  sys_core_pkg::mix_mode_e       mix,
	input  logic [`SYS_VOL_BITS-1:0]      vol_att,
	output logic [`SYS_AUDIO_WIDTH-1:0]   sample_out
);

	import sys_core_pkg::*;

	localparam int W        = `SYS_AUDIO_WIDTH;
	localparam int MUTE_BIT = `SYS_VOL_BITS - 1;

	// Arithmetic or logical right shift
	function automatic logic [W-1:0] shr(
		input logic [W-1:0] v,
		input logic [3:0]   n,
		input logic         arith
	);
		if (arith) begin
			return W'($signed(v) >>> n);
		end
		return v >> n;
	endfunction

	// ============================================================
	// Stage 1 cross-mix
	// ============================================================

	logic [W-1:0] mix_d;
	logic [W-1:0] mix_q;
	logic         signed_q;

	always_comb begin
		case (mix)
			mix_none:    mix_d = own;
			mix_eighth:  mix_d = own - shr(own, 4'd3, audio_signed) +
			                     shr(opposite, 4'd3, audio_signed);
			mix_quarter: mix_d = own - shr(own, 4'd2, audio_signed) +
			                     shr(opposite, 4'd2, audio_signed);
			mix_half:    mix_d = shr(own, 4'd1, audio_signed) +
			                     shr(opposite, 4'd1, audio_signed);
			default:     mix_d = own;
		endcase
	end

	// Shift kind travels with its sample
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_q    <= '0;
			signed_q <= 1'b0;
		end else begin
			mix_q    <= mix_d;
			signed_q <= audio_signed;
		end
	end

	// ============================================================
	// Stage 2 attenuation
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sample_out <= '0;
		end else if (vol_att[MUTE_BIT]) begin
			sample_out <= '0;
		end else begin
			sample_out <= shr(mix_q, vol_att[MUTE_BIT-1:0], signed_q);
		end
	end

	a_mute_zero: assert property (
		@(posedge clk_sys) disable iff (resetd)
		$past(vol_att[MUTE_BIT]) && vol_att[MUTE_BIT] |=> (sample_out == '0)
	) else $error("muted channel produced a nonzero sample");

endmodule

`default_nettype wire

// ==== logic/sys_core_top.sv ====
// Single clock domain and tick_div only scales the button debounce prescaler
`timescale 1ns/1ps
`include "sys_core_macros.svh"
`default_nettype none

module sys_core_top #(
	parameter int tick_div = `SYS_DEB_DIV
) (
	input  logic                       clk_sys,
	input  logic                       resetd,

	// Host link
	input  logic                       io_uio,
	input  logic                       io_clk,
	input  logic [`SYS_IO_WIDTH-1:0]   io_din,
	output logic                       io_ack,
	output sys_core_pkg::video_cfg_t   video_cfg,

	// Front panel
	input  logic                       btn_user_n,
	input  logic                       btn_osd_n,
	input  logic [1:0]                 key_n,
	input  sys_core_pkg::led_req_t     led_req,
	output logic                       btn_user,
	output logic                       btn_osd,
	output logic                       lamp_power,
	output logic                       lamp_disk,
	output logic                       lamp_user,
	output logic [`SYS_LED_COUNT-1:0]  board_led,

	// Audio
	input  sys_core_pkg::audio_pair_t  audio_in,
	input  logic                       audio_signed,
	input  sys_core_pkg::mix_mode_e    audio_mix,
	output sys_core_pkg::audio_pair_t  audio_out
);

	import sys_core_pkg::*;

	host_settings_t              settings;
	logic [`SYS_AUDIO_WIDTH-1:0] chan_in  [2];
	logic [`SYS_AUDIO_WIDTH-1:0] chan_out [2];

	host_link i_host_link (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.io_uio   (io_uio),
		.io_clk   (io_clk),
		.io_din   (io_din),
		.io_ack   (io_ack),
		.settings (settings)
	);

	assign video_cfg = settings.cfg;

	panel_io #(
		.tick_div (tick_div)
	) i_panel_io (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.btn_user_n (btn_user_n),
		.btn_osd_n  (btn_osd_n),
		.key_n      (key_n),
		.led_req    (led_req),
		.settings   (settings),
		.btn_user   (btn_user),
		.btn_osd    (btn_osd),
		.lamp_power (lamp_power),
		.lamp_disk  (lamp_disk),
		.lamp_user  (lamp_user),
		.board_led  (board_led)
	);

	// ============================================================
	// Audio channels with 0 left and 1 right
	// ============================================================

	assign chan_in[0] = audio_in.left;
	assign chan_in[1] = audio_in.right;

	for (genvar ch = 0; ch < 2; ch++) begin : gen_audio
		audio_channel i_audio_channel (
			.clk_sys      (clk_sys),
			.resetd       (resetd),
			.own          (chan_in[ch]),
			.opposite     (chan_in[1-ch]),
			.audio_signed (audio_signed),
			.mix          (audio_mix),
			.vol_att      (settings.vol_att),
			.sample_out   (chan_out[ch])
		);
	end

	assign audio_out = '{left: chan_out[0], right: chan_out[1]};

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Free-running clock from time zero, reset held high for reset_cycles rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int half_period  = 4,
	parameter int reset_cycles = 4
) (
	output logic clk_sys,
	output logic resetd
);

	initial begin
		clk_sys = 1'b0;
		forever #(half_period) clk_sys = ~clk_sys;
	end

	initial begin
		resetd = 1'b1;
		repeat (reset_cycles) @(posedge clk_sys);
		resetd <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/tb_sys_core.sv ====
// Runs the DUT with tick_div 4, checks outputs at the falling edge, stops at the first error
`timescale 1ns/1ps
`include "sys_core_macros.svh"
`default_nettype none

module tb_sys_core;

	import sys_core_pkg::*;

	localparam int TICK_DIV      = 4;
	localparam int ACK_LIMIT     = 16;
	localparam int BTN_LIMIT     = (`SYS_DEB_DEPTH + 3) * TICK_DIV;
	localparam int AUDIO_SAMPLES = 12;
	localparam int LED_SAMPLES   = 8;
	localparam int WATCHDOG      = 100000;

	typedef enum logic [1:0] {
		act_host_write,
		act_led_batch,
		act_button_hold,
		act_audio_batch
	} tb_act_e;

	// cmd doubles as button select, arg as data word, hold cycles or vol_att
	typedef struct packed {
		tb_act_e     act;
		logic [7:0]  cmd;
		logic [15:0] arg;
		logic [1:0]  mix;
		logic        sgn;
		logic [15:0] exp_val;
	} step_t;

	logic                      clk_sys;
	logic                      resetd;
	logic                      io_uio;
	logic                      io_clk;
	logic [`SYS_IO_WIDTH-1:0]  io_din;
	logic                      io_ack;
	video_cfg_t                video_cfg;
	logic                      btn_user_n;
	logic                      btn_osd_n;
	logic [1:0]                key_n;
	led_req_t                  led_req;
	logic                      btn_user;
	logic                      btn_osd;
	logic                      lamp_power;
	logic                      lamp_disk;
	logic                      lamp_user;
	logic [`SYS_LED_COUNT-1:0] board_led;
	audio_pair_t               audio_in;
	logic                      audio_signed;
	mix_mode_e                 audio_mix;
	audio_pair_t               audio_out;

	logic [31:0] lfsr_state = 32'h7d99a93e;
	step_t       steps[$];

	tb_clock_gen #(
		.half_period  (4),
		.reset_cycles (4)
	) i_clock_gen (
		.clk_sys (clk_sys),
		.resetd  (resetd)
	);

	sys_core_top #(
		.tick_div (TICK_DIV)
	) i_sys_core_top (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.io_uio       (io_uio),
		.io_clk       (io_clk),
		.io_din       (io_din),
		.io_ack       (io_ack),
		.video_cfg    (video_cfg),
		.btn_user_n   (btn_user_n),
		.btn_osd_n    (btn_osd_n),
		.key_n        (key_n),
		.led_req      (led_req),
		.btn_user     (btn_user),
		.btn_osd      (btn_osd),
		.lamp_power   (lamp_power),
		.lamp_disk    (lamp_disk),
		.lamp_user    (lamp_user),
		.board_led    (board_led),
		.audio_in     (audio_in),
		.audio_signed (audio_signed),
		.audio_mix    (audio_mix),
		.audio_out    (audio_out)
	);

	// ============================================================
	// Failure reporting, checks and random bits
	// ============================================================

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("CHECK FAILED %s expected %h actual %h",
			                    name, expected, actual));
		end
	endtask

	// Taps 32, 22, 2, 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			bits       = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// ============================================================
	// Reference model
	// ============================================================

	function automatic int shift_ref(input logic [15:0] v, input int n, input logic sgn);
		int val;
		if (sgn) begin
			val = int'($signed(v));
		end else begin
			val = int'(v);
		end
		return val >>> n;
	endfunction

	function automatic logic [15:0] audio_ref(input logic [15:0] own, input logic [15:0] other,
	                                          input logic [1:0] mode, input logic sgn,
	                                          input logic [4:0] vol);
		int          mixed;
		logic [15:0] wrapped;
		case (mix_mode_e'(mode))
			mix_eighth:  mixed = shift_ref(own, 0, sgn) - shift_ref(own, 3, sgn) +
			                     shift_ref(other, 3, sgn);
			mix_quarter: mixed = shift_ref(own, 0, sgn) - shift_ref(own, 2, sgn) +
			                     shift_ref(other, 2, sgn);
			mix_half:    mixed = shift_ref(own, 1, sgn) + shift_ref(other, 1, sgn);
			default:     mixed = shift_ref(own, 0, sgn);
		endcase
		wrapped = 16'(mixed);
		if (vol[4]) begin
			return 16'h0000;
		end
		return 16'(shift_ref(wrapped, int'(vol[3:0]), sgn));
	endfunction

	// High byte of the 25h word is the override mask
	function automatic logic [7:0] board_led_ref(input led_req_t req, input logic [15:0] word);
		logic [7:0] lamps;
		logic [7:0] res;
		lamps    = '0;
		lamps[0] = req.user;
		lamps[2] = req.disk[0];
		lamps[4] = req.power[1] & req.power[0];
		for (int b = 0; b < 8; b++) begin
			res[b] = word[8 + b] ? word[b] : lamps[b];
		end
		return res;
	endfunction

	// ============================================================
	// Host link
	// ============================================================

	task automatic wait_ack(input logic level);
		for (int i = 0; i < ACK_LIMIT; i++) begin
			@(negedge clk_sys);
			if (io_ack === level) begin
				return;
			end
		end
		abort_run($sformatf("Timeout waiting for io_ack to go to %0b", level));
	endtask

	task automatic send_word(input logic [15:0] word);
		@(posedge clk_sys);
		io_din <= word;
		io_clk <= 1'b1;
		wait_ack(1'b1);
		@(posedge clk_sys);
		io_clk <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic host_write(input logic [7:0] cmd, input logic [15:0] data);
		@(posedge clk_sys);
		io_uio <= 1'b1;
		send_word({8'h00, cmd});
		send_word(data);
		@(posedge clk_sys);
		io_uio <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	// ============================================================
	// Buttons
	// ============================================================

	// Select 0 user pin, 1 key 0, 2 OSD pin, 3 key 1
	task automatic drive_button(input logic [7:0] sel, input logic pressed);
		case (sel)
			8'd0:    btn_user_n <= ~pressed;
			8'd1:    key_n[0]   <= ~pressed;
			8'd2:    btn_osd_n  <= ~pressed;
			default: key_n[1]   <= ~pressed;
		endcase
	endtask

	function automatic logic button_value(input logic [7:0] sel);
		return (sel == 8'd0 || sel == 8'd3) ? btn_user : btn_osd;
	endfunction

	task automatic wait_button(input logic [7:0] sel, input logic level);
		for (int i = 0; i < BTN_LIMIT; i++) begin
			@(negedge clk_sys);
			if (button_value(sel) === level) begin
				return;
			end
		end
		abort_run($sformatf("Timeout waiting for button select %0d to go to %0b", sel, level));
	endtask

	task automatic run_button(input step_t s);
		string name;
		name = $sformatf("button select %0d", s.cmd);
		@(posedge clk_sys);
		drive_button(s.cmd, 1'b1);
		if (s.exp_val[0]) begin
			wait_button(s.cmd, 1'b1);
			@(posedge clk_sys);
			drive_button(s.cmd, 1'b0);
			wait_button(s.cmd, 1'b0);
		end else begin
			repeat (int'(s.arg)) @(posedge clk_sys);
			drive_button(s.cmd, 1'b0);
			for (int i = 0; i < BTN_LIMIT; i++) begin
				@(negedge clk_sys);
				check_value({name, " glitch"}, 32'd0, 32'(button_value(s.cmd)));
			end
		end
	endtask

	// ============================================================
	// LED and audio batches
	// ============================================================

	task automatic run_leds(input step_t s);
		led_req_t req;
		host_write(`SYS_CMD_LED, s.arg);
		for (int k = 0; k < LED_SAMPLES; k++) begin
			req = led_req_t'(take_bits(5));
			@(posedge clk_sys);
			led_req <= req;
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value($sformatf("board_led word %h req %h", s.arg, req),
			            32'(board_led_ref(req, s.arg)), 32'(board_led));
			check_value($sformatf("lamps req %h", req),
			            {29'd0, req.power[1] & req.power[0], req.disk[0], req.user},
			            {29'd0, lamp_power, lamp_disk, lamp_user});
		end
	endtask

	task automatic run_audio(input step_t s);
		audio_pair_t smp;
		audio_pair_t want;
		audio_pair_t want_q[$];
		string       name;
		name = $sformatf("audio mix %0d signed %0b vol %h", s.mix, s.sgn, s.arg[4:0]);
		host_write(`SYS_CMD_VOL, s.arg);
		// Two-stage pipeline, so results trail the stimulus by two loop turns
		for (int i = 0; i < AUDIO_SAMPLES + 2; i++) begin
			@(posedge clk_sys);
			if (i < AUDIO_SAMPLES) begin
				smp.left   = 16'(take_bits(16));
				smp.right  = 16'(take_bits(16));
				want.left  = audio_ref(smp.left, smp.right, s.mix, s.sgn, s.arg[4:0]);
				want.right = audio_ref(smp.right, smp.left, s.mix, s.sgn, s.arg[4:0]);
				want_q.push_back(want);
				audio_in     <= smp;
				audio_mix    <= mix_mode_e'(s.mix);
				audio_signed <= s.sgn;
			end
			@(negedge clk_sys);
			if (i >= 2) begin
				check_value($sformatf("%s sample %0d", name, i - 2), want_q.pop_front(),
				            audio_out);
			end
		end
	endtask

	// ============================================================
	// Stimulus table
	// ============================================================

	function automatic step_t make_step(input tb_act_e act, input logic [7:0] cmd,
	                                    input logic [15:0] arg, input logic [1:0] mix,
	                                    input logic sgn, input logic [15:0] exp_val);
		step_t s;
		s.act     = act;
		s.cmd     = cmd;
		s.arg     = arg;
		s.mix     = mix;
		s.sgn     = sgn;
		s.exp_val = exp_val;
		return s;
	endfunction

	task automatic build_table();
		logic [4:0] vols[4];
		vols = '{5'h00, 5'h03, 5'h0f, 5'h12};
		steps.push_back(make_step(act_host_write, `SYS_CMD_CFG, 16'h00e4, 2'd0, 1'b0, 16'h00e4));
		steps.push_back(make_step(act_host_write, 8'h3c, 16'h1234, 2'd0, 1'b0, 16'h00e4));
		steps.push_back(make_step(act_host_write, `SYS_CMD_CFG, 16'h5a2c, 2'd0, 1'b0, 16'h5a2c));
		// 20h is no longer decoded
		steps.push_back(make_step(act_host_write, 8'h20, 16'hffff, 2'd0, 1'b0, 16'h5a2c));
		steps.push_back(make_step(act_led_batch, 8'd0, 16'h0000, 2'd0, 1'b0, 16'h0000));
		steps.push_back(make_step(act_led_batch, 8'd0, 16'hf05a, 2'd0, 1'b0, 16'h0000));
		steps.push_back(make_step(act_led_batch, 8'd0, 16'h15ff, 2'd0, 1'b0, 16'h0000));
		steps.push_back(make_step(act_led_batch, 8'd0, 16'hffa5, 2'd0, 1'b0, 16'h0000));
		steps.push_back(make_step(act_button_hold, 8'd0, 16'd0, 2'd0, 1'b0, 16'h0001));
		steps.push_back(make_step(act_button_hold, 8'd1, 16'd0, 2'd0, 1'b0, 16'h0001));
		steps.push_back(make_step(act_button_hold, 8'd2, 16'd0, 2'd0, 1'b0, 16'h0001));
		steps.push_back(make_step(act_button_hold, 8'd3, 16'd0, 2'd0, 1'b0, 16'h0001));
		steps.push_back(make_step(act_button_hold, 8'd0, 16'(TICK_DIV), 2'd0, 1'b0, 16'h0000));
		steps.push_back(make_step(act_button_hold, 8'd1, 16'(TICK_DIV), 2'd0, 1'b0, 16'h0000));
		for (int m = 0; m < 4; m++) begin
			for (int sg = 0; sg < 2; sg++) begin
				foreach (vols[v]) begin
					steps.push_back(make_step(act_audio_batch, 8'd0, {11'd0, vols[v]},
					                          2'(m), 1'(sg), 16'h0000));
				end
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		io_uio       = 1'b0;
		io_clk       = 1'b0;
		io_din       = '0;
		btn_user_n   = 1'b1;
		btn_osd_n    = 1'b1;
		key_n        = 2'b11;
		led_req      = '0;
		audio_in     = '0;
		audio_signed = 1'b0;
		audio_mix    = mix_none;
		build_table();

		for (int i = 0; i <= 20; i++) begin
			@(negedge clk_sys);
			if (!resetd) begin
				break;
			end
			if (i == 20) begin
				abort_run("Reset was never released");
			end
		end
		check_value("reset io_ack", 32'd0, 32'(io_ack));
		check_value("reset video_cfg", 32'd0, 32'(video_cfg));
		check_value("reset board_led", 32'd0, 32'(board_led));
		check_value("reset buttons", 32'd0, {30'd0, btn_user, btn_osd});
		check_value("reset audio_out", 32'd0, audio_out);

		foreach (steps[i]) begin
			case (steps[i].act)
				act_host_write: begin
					host_write(steps[i].cmd, steps[i].arg);
					check_value($sformatf("video_cfg after cmd %h", steps[i].cmd),
					            32'(steps[i].exp_val), 32'(video_cfg));
				end
				act_led_batch:   run_leds(steps[i]);
				act_button_hold: run_button(steps[i]);
				default:         run_audio(steps[i]);
			endcase
		end

		$display("No errors");
		$finish;
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk_sys);
		abort_run("Simulation ran past its cycle limit");
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+logic
logic/sys_core_pkg.sv
logic/host_link.sv
logic/panel_io.sv
logic/audio_channel.sv
logic/sys_core_top.sv
test/tb_clock_gen.sv
test/tb_sys_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f \
	--top-module tb_sys_core \
	-Mdir obj_dir

./obj_dir/Vtb_sys_core
